//--- vlog.f
rv_isa_pkg.sv
core_cfg_pkg.sv
reg_file.sv
alu.sv
decoder.sv
hazard_unit.sv
load_store_unit.sv
riscv_core.sv
tb_riscv_core.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_riscv_core -f vlog.f > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_riscv_core > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1

//--- tb_riscv_core.sv
`default_nettype none

module tb_riscv_core
   import core_cfg_pkg::*;
   import rv_isa_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   logic     clk;
   logic     rst;
   logic     stall;
   word_t    icache_addr;
   logic     icache_re;
   word_t    instruction;
   word_t    dcache_addr;
   word_t    dcache_din;
   byte_en_t dcache_we;
   logic     dcache_re;
   word_t    dcache_dout;

   // Memory images and the reference store list
   word_t    imem [0:255];
   word_t    dmem [0:255];
   word_t    ref_mem [0:255];
   word_t    prog [$];
   word_t    exp_addr [$];
   byte_en_t exp_be [$];
   word_t    exp_data [$];

   int       store_idx;
   int       stall_cycles;
   logic     stall_en;
   integer   seed = 32'h6ea50576;

   // Memory port values seen in the cycle before an edge
   logic     fetch_re_q;
   word_t    fetch_addr_q;
   logic     data_re_q;
   byte_en_t data_we_q;
   word_t    data_addr_q;
   word_t    data_wdata_q;
   word_t    lane_bits;

   riscv_core dut (
      .clk         (clk),
      .rst         (rst),
      .stall       (stall),
      .icache_addr (icache_addr),
      .icache_re   (icache_re),
      .instruction (instruction),
      .dcache_addr (dcache_addr),
      .dcache_din  (dcache_din),
      .dcache_we   (dcache_we),
      .dcache_re   (dcache_re),
      .dcache_dout (dcache_dout)
   );

   always #10 clk = ~clk;

   function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
      return {f7, rs2, rs1, f3, rd, OP};
   endfunction

   function automatic word_t i_type(input opcode_e opc, input logic [2:0] f3,
                                    input reg_idx_t rd, input reg_idx_t rs1, input word_t imm);
      return {imm[11:0], rs1, f3, rd, opc};
   endfunction

   function automatic word_t s_type(input logic [2:0] f3, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input word_t imm);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE};
   endfunction

   function automatic word_t b_type(input logic [2:0] f3, input reg_idx_t rs1,
                                    input reg_idx_t rs2, input word_t imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
   endfunction

   function automatic word_t u_type(input opcode_e opc, input reg_idx_t rd, input word_t imm20);
      return {imm20[19:0], rd, opc};
   endfunction

   function automatic word_t j_type(input reg_idx_t rd, input word_t imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
   endfunction

   // Initial data memory contents
   function automatic word_t fill_word(input int idx);
      return (word_t'(idx) * 32'h9e37_79b9) ^ 32'h5a3c_c3a5;
   endfunction

   function automatic word_t lane_mask(input byte_en_t be);
      return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
   endfunction

   // RV32I arithmetic as the ISA defines it
   function automatic word_t compute_alu(input logic [2:0] f3, input logic alt,
                                         input word_t a, input word_t b);
      case (f3)
         F3_ADD_SUB: return alt ? a - b : a + b;
         F3_SLL:     return a << b[4:0];
         F3_SLT:     return {31'b0, $signed(a) < $signed(b)};
         F3_SLTU:    return {31'b0, a < b};
         F3_XOR:     return a ^ b;
         F3_SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         F3_OR:      return a | b;
         default:    return a & b;
      endcase
   endfunction

   // Instruction-level model of the program, collecting every store
   function automatic bit run_iss();
      word_t      r [0:31];
      word_t      pc;
      word_t      next_pc;
      word_t      ins;
      word_t      a;
      word_t      b;
      word_t      res;
      word_t      addr;
      word_t      w;
      word_t      imm_i;
      word_t      imm_s;
      word_t      imm_b;
      word_t      imm_j;
      logic [2:0] f3;
      reg_idx_t   rd;
      logic       wr;
      logic       take;
      byte_en_t   be;
      int         step;
      int         i;
      for (i = 0; i < 32; i++)
         r[i] = '0;
      for (i = 0; i < 256; i++)
         ref_mem[i] = fill_word(i);
      exp_addr.delete();
      exp_be.delete();
      exp_data.delete();
      pc = RESET_PC;
      for (step = 0; step < 5000; step++)
      begin
         ins = imem[pc[9:2]];
         // The final self-loop ends the program
         if (ins == j_type(0, 0))
            return 1'b1;
         f3      = ins[14:12];
         rd      = ins[11:7];
         a       = r[ins[19:15]];
         b       = r[ins[24:20]];
         imm_i   = {{20{ins[31]}}, ins[31:20]};
         imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         next_pc = pc + 32'd4;
         wr      = 1'b1;
         res     = '0;
         case (ins[6:0])
            OP:     res = compute_alu(f3, ins[30], a, b);
            OP_IMM: res = compute_alu(f3, ins[30] && (f3 == F3_SRL_SRA), a, imm_i);
            LUI:    res = {ins[31:12], 12'b0};
            AUIPC:  res = pc + {ins[31:12], 12'b0};
            LOAD:
            begin
               addr = a + imm_i;
               w    = ref_mem[addr[9:2]] >> (8 * addr[1:0]);
               case (f3)
                  F3_BYTE:   res = {{24{w[7]}}, w[7:0]};
                  F3_BYTE_U: res = {24'b0, w[7:0]};
                  F3_HALF:   res = {{16{w[15]}}, w[15:0]};
                  F3_HALF_U: res = {16'b0, w[15:0]};
                  default:   res = w;
               endcase
            end
            STORE:
            begin
               addr = a + imm_s;
               wr   = 1'b0;
               case (f3)
                  F3_BYTE:
                  begin
                     be = 4'b0001 << addr[1:0];
                     w  = {24'b0, b[7:0]} << (8 * addr[1:0]);
                  end
                  F3_HALF:
                  begin
                     be = 4'b0011 << addr[1:0];
                     w  = {16'b0, b[15:0]} << (8 * addr[1:0]);
                  end
                  default:
                  begin
                     be = 4'b1111;
                     w  = b;
                  end
               endcase
               exp_addr.push_back(addr);
               exp_be.push_back(be);
               exp_data.push_back(w);
               for (i = 0; i < 4; i++)
                  if (be[i])
                     ref_mem[addr[9:2]][8*i +: 8] = w[8*i +: 8];
            end
            BRANCH:
            begin
               wr = 1'b0;
               case (f3)
                  F3_BEQ:  take = (a == b);
                  F3_BNE:  take = (a != b);
                  F3_BLT:  take = ($signed(a) < $signed(b));
                  F3_BGE:  take = ($signed(a) >= $signed(b));
                  default: take = 1'b0;
               endcase
               if (take)
                  next_pc = pc + imm_b;
            end
            JAL:
            begin
               res     = pc + 32'd4;
               next_pc = pc + imm_j;
            end
            JALR:
            begin
               res     = pc + 32'd4;
               next_pc = (a + imm_i) & ~32'd1;
            end
            default: wr = 1'b0;
         endcase
         if (wr && (rd != '0))
            r[rd] = res;
         pc = next_pc;
      end
      return 1'b0;
   endfunction

   task automatic build_program();
      int i;
      // ALU, immediates and forwarding, results stored from 0x200 up
      prog.push_back(u_type(LUI, 1, 32'h12345));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 1, 1, 32'h678));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 10, 0, 32'h200));
      prog.push_back(s_type(F3_WORD, 1, 10, 0));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 2, 0, -5));
      prog.push_back(r_type(7'h00, F3_ADD_SUB, 3, 1, 2));
      prog.push_back(r_type(7'h20, F3_ADD_SUB, 4, 3, 1));
      prog.push_back(s_type(F3_WORD, 3, 10, 4));
      prog.push_back(s_type(F3_WORD, 4, 10, 8));
      prog.push_back(r_type(7'h00, F3_AND, 5, 1, 2));
      prog.push_back(r_type(7'h00, F3_OR, 6, 1, 2));
      prog.push_back(r_type(7'h00, F3_XOR, 7, 1, 2));
      prog.push_back(s_type(F3_WORD, 5, 10, 12));
      prog.push_back(s_type(F3_WORD, 6, 10, 16));
      prog.push_back(s_type(F3_WORD, 7, 10, 20));
      prog.push_back(r_type(7'h00, F3_SLT, 8, 2, 1));
      prog.push_back(r_type(7'h00, F3_SLTU, 9, 2, 1));
      prog.push_back(s_type(F3_WORD, 8, 10, 24));
      prog.push_back(s_type(F3_WORD, 9, 10, 28));
      prog.push_back(i_type(OP_IMM, F3_SLL, 8, 1, 4));
      prog.push_back(i_type(OP_IMM, F3_SRL_SRA, 9, 2, 32'h402));
      prog.push_back(i_type(OP_IMM, F3_SRL_SRA, 11, 2, 3));
      prog.push_back(r_type(7'h00, F3_SLL, 12, 1, 2));
      prog.push_back(s_type(F3_WORD, 8, 10, 32));
      prog.push_back(s_type(F3_WORD, 9, 10, 36));
      prog.push_back(s_type(F3_WORD, 11, 10, 40));
      prog.push_back(s_type(F3_WORD, 12, 10, 44));
      prog.push_back(u_type(AUIPC, 11, 1));
      prog.push_back(s_type(F3_WORD, 11, 10, 48));
      prog.push_back(i_type(OP_IMM, F3_SLTU, 13, 1, -1));
      prog.push_back(s_type(F3_WORD, 13, 10, 52));
      // Byte and half stores on every lane
      for (i = 0; i < 4; i++)
         prog.push_back(s_type(F3_BYTE, 1, 10, 64 + i));
      prog.push_back(s_type(F3_HALF, 3, 10, 68));
      prog.push_back(s_type(F3_HALF, 3, 10, 70));
      // Loads straight into dependent stores
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 15, 0, 32'h80));
      prog.push_back(i_type(LOAD, F3_BYTE, 16, 15, 1));
      prog.push_back(s_type(F3_WORD, 16, 10, 72));
      prog.push_back(i_type(LOAD, F3_BYTE_U, 16, 15, 3));
      prog.push_back(s_type(F3_WORD, 16, 10, 76));
      prog.push_back(i_type(LOAD, F3_HALF, 16, 15, 2));
      prog.push_back(s_type(F3_WORD, 16, 10, 80));
      prog.push_back(i_type(LOAD, F3_HALF_U, 16, 15, 6));
      prog.push_back(s_type(F3_WORD, 16, 10, 84));
      prog.push_back(i_type(LOAD, F3_WORD, 16, 10, 64));
      prog.push_back(s_type(F3_WORD, 16, 10, 88));
      prog.push_back(i_type(LOAD, F3_HALF, 16, 10, 70));
      prog.push_back(s_type(F3_BYTE, 16, 10, 92));
      // Each branch kind taken and not taken, x12 collects the fall-through marks
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 12, 0, 0));
      prog.push_back(b_type(F3_BEQ, 1, 1, 8));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 12, 12, 1));
      prog.push_back(b_type(F3_BNE, 1, 1, 8));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 12, 12, 2));
      prog.push_back(b_type(F3_BLT, 2, 1, 8));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 12, 12, 4));
      prog.push_back(b_type(F3_BGE, 2, 1, 8));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 12, 12, 8));
      prog.push_back(b_type(F3_BNE, 2, 1, 8));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 12, 12, 16));
      prog.push_back(b_type(F3_BLT, 1, 2, 8));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 12, 12, 32));
      prog.push_back(b_type(F3_BGE, 1, 2, 8));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 12, 12, 64));
      prog.push_back(b_type(F3_BEQ, 1, 2, 8));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 12, 12, 128));
      prog.push_back(s_type(F3_WORD, 12, 10, 96));
      // JAL and JALR with the link values stored
      prog.push_back(j_type(13, 8));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 12, 12, 256));
      prog.push_back(s_type(F3_WORD, 13, 10, 100));
      prog.push_back(u_type(AUIPC, 14, 0));
      prog.push_back(i_type(JALR, 3'b000, 15, 14, 13));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 12, 12, 512));
      prog.push_back(s_type(F3_WORD, 15, 10, 104));
      prog.push_back(s_type(F3_WORD, 12, 10, 108));
      // Short countdown loop with a backward branch
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 16, 0, 3));
      prog.push_back(i_type(OP_IMM, F3_ADD_SUB, 16, 16, -1));
      prog.push_back(s_type(F3_WORD, 16, 10, 112));
      prog.push_back(b_type(F3_BNE, 16, 0, -8));
      prog.push_back(j_type(0, 0));
      for (i = 0; i < 256; i++)
         imem[i] = (i < prog.size()) ? prog[i] : NOP_INSTR;
   endtask

   task automatic stop_with_failure();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_be(input string name, input byte_en_t got, input byte_en_t exp);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic expect_quiet_memory();
      check_be("dcache_we", dcache_we, '0);
      check_bit("dcache_re", dcache_re, 1'b0);
   endtask

   // Five reset edges, then the data port must stay idle for two more cycles
   task automatic apply_reset();
      int i;
      int j;
      if (rst == 1'b0)
      begin
         @(posedge clk);
         #1;
         rst = 1'b1;
      end
      store_idx = 0;
      for (j = 0; j < 256; j++)
         dmem[j] = fill_word(j);
      for (i = 0; i < 5; i++)
      begin
         @(posedge clk);
         #1;
         if (i == 4)
            rst = 1'b0;
         @(negedge clk);
         expect_quiet_memory();
      end
      @(negedge clk);
      expect_quiet_memory();
   endtask

   task automatic wait_for_stores(input int count, input int limit);
      int cycles;
      cycles = 0;
      while (store_idx < count)
      begin
         if (cycles >= limit)
         begin
            $display("Timeout: only %0d of %0d stores seen after %0d cycles",
                     store_idx, count, limit);
            stop_with_failure();
         end
         @(posedge clk);
         cycles++;
      end
   endtask

   task automatic run_program(input logic use_stall);
      apply_reset();
      stall_cycles = 0;
      stall_en     = use_stall;
      wait_for_stores(exp_addr.size(), 3000);
      // Let the final loop spin so a stray store would still show up
      repeat (10) @(posedge clk);
      stall_en = 1'b0;
      if (use_stall && (stall_cycles == 0))
      begin
         $display("The random stall input was never asserted");
         stop_with_failure();
      end
   endtask

   // Memory ports sampled mid-cycle, answered just after the edge
   always @(negedge clk)
   begin
      fetch_re_q   = icache_re;
      fetch_addr_q = icache_addr;
      data_re_q    = dcache_re;
      data_we_q    = dcache_we;
      data_addr_q  = dcache_addr;
      data_wdata_q = dcache_din;
   end

   always @(posedge clk)
   begin
      #1;
      if (fetch_re_q === 1'b1)
         instruction = imem[fetch_addr_q[9:2]];
      if (data_re_q === 1'b1)
         dcache_dout = dmem[data_addr_q[9:2]];
      for (int lane = 0; lane < 4; lane++)
         if (data_we_q[lane] === 1'b1)
            dmem[data_addr_q[9:2]][8*lane +: 8] = data_wdata_q[8*lane +: 8];
   end

   always @(posedge clk)
   begin
      #1;
      if (stall_en)
         stall = (($random(seed) & 3) < 2);
      else
         stall = 1'b0;
   end

   // Store compare against the reference list
   always @(negedge clk)
   begin
      if (!rst && stall)
      begin
         stall_cycles++;
         check_be("dcache_we", dcache_we, '0);
         check_bit("dcache_re", dcache_re, 1'b0);
         check_bit("icache_re", icache_re, 1'b0);
      end
      if (!rst && (dcache_we != '0))
      begin
         if (store_idx >= exp_addr.size())
         begin
            $display("Store at %0t goes beyond the expected %0d stores", $time, exp_addr.size());
            stop_with_failure();
         end
         lane_bits = lane_mask(exp_be[store_idx]);
         check_word("dcache_addr", dcache_addr, exp_addr[store_idx]);
         check_be("dcache_we", dcache_we, exp_be[store_idx]);
         check_word("dcache_din", dcache_din & lane_bits, exp_data[store_idx] & lane_bits);
         store_idx++;
      end
   end

   initial
   begin
      clk          = 1'b0;
      rst          = 1'b1;
      stall        = 1'b0;
      instruction  = NOP_INSTR;
      dcache_dout  = '0;
      stall_en     = 1'b0;
      store_idx    = 0;
      stall_cycles = 0;
      build_program();
      if (!run_iss())
      begin
         $display("Reference model never reached the final self-loop");
         stop_with_failure();
      end
      run_program(1'b0);
      run_program(1'b1);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

//--- riscv_core.sv
`default_nettype none

module riscv_core
   import core_cfg_pkg::*;
   import rv_isa_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  rst,
   input  wire logic  stall,
   output word_t      icache_addr,
   output logic       icache_re,
   input  wire word_t instruction,
   output word_t      dcache_addr,
   output word_t      dcache_din,
   output byte_en_t   dcache_we,
   output logic       dcache_re,
   input  wire word_t dcache_dout
);

   // Fetch and execute state
   word_t      pc;
   word_t      ex_pc;
   logic       ex_flush;
   word_t      ex_instr;

   // Decoded controls
   reg_idx_t   rs1;
   reg_idx_t   rs2;
   reg_idx_t   rd;
   word_t      imm;
   alu_op_e    alu_op;
   logic       src_a_pc;
   logic       src_b_imm;
   logic       reg_we;
   wb_sel_e    wb_sel;
   logic       is_load;
   logic       is_store;
   logic       is_branch;
   logic       is_jal;
   logic       is_jalr;
   logic [2:0] funct3;

   // Execute datapath
   word_t      rd1;
   word_t      rd2;
   logic       fwd_a;
   logic       fwd_b;
   word_t      op_a;
   word_t      op_b;
   word_t      alu_a;
   word_t      alu_b;
   word_t      alu_result;
   logic       redirect;
   word_t      target;
   byte_en_t   mem_be;
   word_t      mem_wdata;

   // Writeback stage
   word_t      wb_result;
   reg_idx_t   wb_rd;
   logic       wb_we;
   wb_sel_e    wb_sel_q;
   logic [2:0] wb_ld_funct3;
   logic [1:0] wb_ld_offset;
   word_t      wb_pc4;
   word_t      ld_result;
   word_t      wb_value;

   // Flushed or reset slot executes as a NOP
   assign ex_instr = ex_flush ? NOP_INSTR : instruction;

   decoder u_decoder (
      .instr     (ex_instr),
      .rs1       (rs1),
      .rs2       (rs2),
      .rd        (rd),
      .imm       (imm),
      .alu_op    (alu_op),
      .src_a_pc  (src_a_pc),
      .src_b_imm (src_b_imm),
      .reg_we    (reg_we),
      .wb_sel    (wb_sel),
      .is_load   (is_load),
      .is_store  (is_store),
      .is_branch (is_branch),
      .is_jal    (is_jal),
      .is_jalr   (is_jalr),
      .funct3    (funct3)
   );

   reg_file u_reg_file (
      .clk (clk),
      .we  (wb_we && !stall),
      .ra1 (rs1),
      .ra2 (rs2),
      .wa  (wb_rd),
      .wd  (wb_value),
      .rd1 (rd1),
      .rd2 (rd2)
   );

   hazard_unit u_hazard_unit (
      .ex_rs1    (rs1),
      .ex_rs2    (rs2),
      .wb_rd     (wb_rd),
      .wb_we     (wb_we),
      .fwd_a     (fwd_a),
      .fwd_b     (fwd_b),
      .is_branch (is_branch),
      .is_jal    (is_jal),
      .is_jalr   (is_jalr),
      .funct3    (funct3),
      .op_a      (op_a),
      .op_b      (op_b),
      .ex_pc     (ex_pc),
      .imm       (imm),
      .redirect  (redirect),
      .target    (target)
   );

   assign op_a  = fwd_a ? wb_value : rd1;
   assign op_b  = fwd_b ? wb_value : rd2;
   assign alu_a = src_a_pc ? ex_pc : op_a;
   assign alu_b = src_b_imm ? imm : op_b;

   alu u_alu (
      .a      (alu_a),
      .b      (alu_b),
      .op     (alu_op),
      .result (alu_result)
   );

   load_store_unit u_lsu (
      .is_store  (is_store),
      .st_funct3 (funct3),
      .addr      (alu_result),
      .st_data   (op_b),
      .mem_be    (mem_be),
      .mem_wdata (mem_wdata),
      .ld_funct3 (wb_ld_funct3),
      .ld_offset (wb_ld_offset),
      .mem_rdata (dcache_dout),
      .ld_result (ld_result)
   );

   // Memory ports, all quiet while stalled
   assign icache_addr = pc;
   assign icache_re   = !stall;
   assign dcache_addr = alu_result;
   assign dcache_din  = mem_wdata;
   assign dcache_we   = stall ? '0 : mem_be;
   assign dcache_re   = is_load && !stall;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc       <= RESET_PC;
         ex_flush <= 1'b1;
         wb_we    <= 1'b0;
      end
      else if (!stall)
      begin
         pc       <= redirect ? target : pc + 32'd4;
         // Kill the fall-through instruction behind a taken transfer
         ex_flush <= redirect;
         wb_we    <= reg_we;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         ex_pc        <= pc;
         wb_result    <= alu_result;
         wb_rd        <= rd;
         wb_sel_q     <= wb_sel;
         wb_ld_funct3 <= funct3;
         wb_ld_offset <= alu_result[1:0];
         wb_pc4       <= ex_pc + 32'd4;
      end
   end

   always_comb
   begin
      case (wb_sel_q)
         WB_LOAD: wb_value = ld_result;
         WB_LINK: wb_value = wb_pc4;
         default: wb_value = wb_result;
      endcase
   end

   // Pipeline state is frozen for the whole stall
   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      stall |=> $stable(pc) && $stable(ex_flush) && $stable(wb_we) && $stable(wb_result));

endmodule

`default_nettype wire

//--- load_store_unit.sv
`default_nettype none

module load_store_unit
   import core_cfg_pkg::*;
   import rv_isa_pkg::*;
(
   input  wire logic       is_store,
   input  wire logic [2:0] st_funct3,
   input  wire word_t      addr,
   input  wire word_t      st_data,
   output byte_en_t        mem_be,
   output word_t           mem_wdata,
   input  wire logic [2:0] ld_funct3,
   input  wire logic [1:0] ld_offset,
   input  wire word_t      mem_rdata,
   output word_t           ld_result
);

   logic [1:0] st_offset;
   word_t      ld_shifted;

   assign st_offset = addr[1:0];

   // Store side runs in execute
   always_comb
   begin
      case (st_funct3)
         F3_BYTE:
         begin
            mem_be    = 4'b0001 << st_offset;
            mem_wdata = {4{st_data[7:0]}};
         end
         F3_HALF:
         begin
            mem_be    = 4'b0011 << {st_offset[1], 1'b0};
            mem_wdata = {2{st_data[15:0]}};
         end
         default:
         begin
            mem_be    = 4'b1111;
            mem_wdata = st_data;
         end
      endcase
      if (!is_store)
      begin
         mem_be = '0;
      end
   end

   // Load side runs in writeback on the registered offset
   assign ld_shifted = mem_rdata >> {ld_offset, 3'b000};

   always_comb
   begin
      case (ld_funct3)
         F3_BYTE:   ld_result = {{24{ld_shifted[7]}}, ld_shifted[7:0]};
         F3_BYTE_U: ld_result = {24'b0, ld_shifted[7:0]};
         F3_HALF:   ld_result = {{16{ld_shifted[15]}}, ld_shifted[15:0]};
         F3_HALF_U: ld_result = {16'b0, ld_shifted[15:0]};
         default:   ld_result = mem_rdata;
      endcase
   end

   // Stores are naturally aligned so the lanes match the address
   always_comb
   begin
      a_be_shape: assert (!is_store || (st_funct3 == F3_BYTE) ||
                          ((st_funct3 == F3_HALF) ? !st_offset[0] : (st_offset == 2'b00)));
   end

endmodule

`default_nettype wire

//--- hazard_unit.sv
`default_nettype none

module hazard_unit
   import core_cfg_pkg::*;
   import rv_isa_pkg::*;
(
   input  wire reg_idx_t   ex_rs1,
   input  wire reg_idx_t   ex_rs2,
   input  wire reg_idx_t   wb_rd,
   input  wire logic       wb_we,
   output logic            fwd_a,
   output logic            fwd_b,
   input  wire logic       is_branch,
   input  wire logic       is_jal,
   input  wire logic       is_jalr,
   input  wire logic [2:0] funct3,
   input  wire word_t      op_a,
   input  wire word_t      op_b,
   input  wire word_t      ex_pc,
   input  wire word_t      imm,
   output logic            redirect,
   output word_t           target
);

   logic  taken;
   word_t jalr_sum;

   // Writeback result bypasses the register file
   assign fwd_a = wb_we && (wb_rd == ex_rs1) && (ex_rs1 != '0);
   assign fwd_b = wb_we && (wb_rd == ex_rs2) && (ex_rs2 != '0);

   always_comb
   begin
      case (funct3)
         F3_BEQ:  taken = (op_a == op_b);
         F3_BNE:  taken = (op_a != op_b);
         F3_BLT:  taken = ($signed(op_a) < $signed(op_b));
         F3_BGE:  taken = ($signed(op_a) >= $signed(op_b));
         default: taken = 1'b0;
      endcase
   end

   assign redirect = is_jal || is_jalr || (is_branch && taken);

   assign jalr_sum = op_a + imm;
   assign target   = is_jalr ? {jalr_sum[31:1], 1'b0} : (ex_pc + imm);

endmodule

`default_nettype wire

//--- decoder.sv
`default_nettype none

module decoder
   import core_cfg_pkg::*;
   import rv_isa_pkg::*;
(
   input  wire word_t instr,
   output reg_idx_t   rs1,
   output reg_idx_t   rs2,
   output reg_idx_t   rd,
   output word_t      imm,
   output alu_op_e    alu_op,
   output logic       src_a_pc,
   output logic       src_b_imm,
   output logic       reg_we,
   output wb_sel_e    wb_sel,
   output logic       is_load,
   output logic       is_store,
   output logic       is_branch,
   output logic       is_jal,
   output logic       is_jalr,
   output logic [2:0] funct3
);

   opcode_e opcode;
   word_t   imm_i;
   word_t   imm_s;
   word_t   imm_b;
   word_t   imm_u;
   word_t   imm_j;
   logic    write_rd;
   logic    alt;

   // Map funct3 and the funct7 alternate bit to an ALU function
   function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt_bit);
      case (f3)
         F3_ADD_SUB: arith_op = alt_bit ? ALU_SUB : ALU_ADD;
         F3_SLL:     arith_op = ALU_SLL;
         F3_SLT:     arith_op = ALU_SLT;
         F3_SLTU:    arith_op = ALU_SLTU;
         F3_XOR:     arith_op = ALU_XOR;
         F3_SRL_SRA: arith_op = alt_bit ? ALU_SRA : ALU_SRL;
         F3_OR:      arith_op = ALU_OR;
         default:    arith_op = ALU_AND;
      endcase
   endfunction

   assign opcode = opcode_e'(instr[6:0]);
   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign alt    = instr[30];

   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb
   begin
      imm       = '0;
      alu_op    = ALU_ADD;
      src_a_pc  = 1'b0;
      src_b_imm = 1'b0;
      write_rd  = 1'b0;
      wb_sel    = WB_ALU;
      is_load   = 1'b0;
      is_store  = 1'b0;
      is_branch = 1'b0;
      is_jal    = 1'b0;
      is_jalr   = 1'b0;
      case (opcode)
         OP:
         begin
            alu_op   = arith_op(funct3, alt);
            write_rd = 1'b1;
         end
         OP_IMM:
         begin
            // Bit 30 selects SRAI only, elsewhere it belongs to the immediate
            alu_op    = arith_op(funct3, alt && (funct3 == F3_SRL_SRA));
            imm       = imm_i;
            src_b_imm = 1'b1;
            write_rd  = 1'b1;
         end
         LUI:
         begin
            alu_op    = ALU_PASS_B;
            imm       = imm_u;
            src_b_imm = 1'b1;
            write_rd  = 1'b1;
         end
         AUIPC:
         begin
            imm       = imm_u;
            src_a_pc  = 1'b1;
            src_b_imm = 1'b1;
            write_rd  = 1'b1;
         end
         LOAD:
         begin
            imm       = imm_i;
            src_b_imm = 1'b1;
            write_rd  = 1'b1;
            wb_sel    = WB_LOAD;
            is_load   = 1'b1;
         end
         STORE:
         begin
            imm       = imm_s;
            src_b_imm = 1'b1;
            is_store  = 1'b1;
         end
         BRANCH:
         begin
            imm       = imm_b;
            is_branch = 1'b1;
         end
         JAL:
         begin
            imm      = imm_j;
            write_rd = 1'b1;
            wb_sel   = WB_LINK;
            is_jal   = 1'b1;
         end
         JALR:
         begin
            imm       = imm_i;
            src_b_imm = 1'b1;
            write_rd  = 1'b1;
            wb_sel    = WB_LINK;
            is_jalr   = 1'b1;
         end
         default:
         begin
            // Unknown opcode behaves as a NOP
            imm = '0;
         end
      endcase
   end

   // No writes to x0
   assign reg_we = write_rd && (rd != '0);

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu
   import core_cfg_pkg::*;
   import rv_isa_pkg::*;
(
   input  wire word_t   a,
   input  wire word_t   b,
   input  wire alu_op_e op,
   output word_t        result
);

   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb
   begin
      case (op)
         ALU_ADD:    result = a + b;
         ALU_SUB:    result = a - b;
         ALU_AND:    result = a & b;
         ALU_OR:     result = a | b;
         ALU_XOR:    result = a ^ b;
         ALU_SLT:
         begin
            result = {31'b0, $signed(a) < $signed(b)};
         end
         ALU_SLTU:
         begin
            result = {31'b0, a < b};
         end
         ALU_SLL:    result = a << shamt;
         ALU_SRL:    result = a >> shamt;
         // Arithmetic shift keeps the sign bit
         ALU_SRA:    result = word_t'($signed(a) >>> shamt);
         // LUI passes the upper immediate through
         ALU_PASS_B: result = b;
         default:    result = a + b;
      endcase
   end

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file
   import core_cfg_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     we,
   input  wire reg_idx_t ra1,
   input  wire reg_idx_t ra2,
   input  wire reg_idx_t wa,
   input  wire word_t    wd,
   output word_t         rd1,
   output word_t         rd2
);

   // x0 has no storage
   word_t regs [1:31];

   always_ff @(posedge clk)
   begin
      if (we && (wa != '0))
      begin
         regs[wa] <= wd;
      end
   end

   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

   // Decoder drops the write enable for rd zero, so a write to x0 never reaches here
   a_no_x0_write: assert property (@(posedge clk) we |-> (wa != '0));

endmodule

`default_nettype wire

//--- core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

   typedef logic [31:0] word_t;
   typedef logic [3:0]  byte_en_t;
   typedef logic [4:0]  reg_idx_t;

   // First fetch address out of reset
   localparam word_t RESET_PC = 32'h0000_0000;

   // Source of the value written back to rd
   typedef enum logic [1:0] {
      WB_ALU,
      WB_LOAD,
      WB_LINK
   } wb_sel_e;

endpackage

`default_nettype wire

//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

   // RV32I major opcodes covered by the core
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LUI    = 7'b0110111,
      AUIPC  = 7'b0010111,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JAL    = 7'b1101111,
      JALR   = 7'b1100111
   } opcode_e;

   // ALU functions
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_PASS_B
   } alu_op_e;

   // Arithmetic funct3 codes
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SRL_SRA = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   // Branch conditions
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;
   localparam logic [2:0] F3_BLT = 3'b100;
   localparam logic [2:0] F3_BGE = 3'b101;

   // Load and store sizes
   localparam logic [2:0] F3_BYTE   = 3'b000;
   localparam logic [2:0] F3_HALF   = 3'b001;
   localparam logic [2:0] F3_WORD   = 3'b010;
   localparam logic [2:0] F3_BYTE_U = 3'b100;
   localparam logic [2:0] F3_HALF_U = 3'b101;

   // ADDI x0, x0, 0
   localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire
